// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_zx_pager
RTL_TOP   ?= zx_pager_top
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) zx_params.svh
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== map_state_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

interface map_state_if ();

	// paging registers as last written
	logic [`DATA_W-1:0] p7ffd;
	logic [`DATA_W-1:0] eff7;
	logic               dos;

	modport source
	(
		output p7ffd, eff7, dos
	);

	modport sink
	(
		input p7ffd, eff7, dos
	);

endinterface

`default_nettype wire

// ==== port_cycle_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

interface port_cycle_if import zx_bus_pkg::*; ();

	logic                stb;
	cycle_kind_e         kind;
	port_addr_u          addr;
	logic [`DATA_W-1:0]  wdata;
	logic                rd_active;

	modport source
	(
		output stb, kind, addr, wdata, rd_active
	);

	modport sink
	(
		input stb, kind, addr, wdata, rd_active
	);

endinterface

`default_nettype wire

// ==== tb.f ====
+incdir+.
zx_bus_pkg.sv
zx_map_pkg.sv
port_cycle_if.sv
map_state_if.sv
zx_bus_decode.sv
zx_port_regs.sv
zx_mem_pager.sv
zx_port_readback.sv
zx_pager_top.sv
zx_pager_checker.sv
tb_zx_pager.sv

// ==== tb_zx_pager.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

module tb_zx_pager;

	localparam int CLK_NS    = 4;
	localparam int OP_CYCLES = 9;
	// upper bound of bus operations below, each may be followed by a sweep
	localparam int NUM_OPS     = 40;
	localparam int TEST_CYCLES = NUM_OPS * (OP_CYCLES + `NUM_WIN) + 16;

	logic               fclk;
	logic               rst;
	logic [`ADDR_W-1:0] a;
	logic [`DATA_W-1:0] d_in;
	logic               iorq_n, mreq_n, rd_n, wr_n, m1_n;
	logic [`DATA_W-1:0] d_out;
	logic               d_oe;
	logic [`PAGE_W-1:0] mem_page;
	logic               mem_rom;
	logic [2:0]         border;
	logic               dos;
	logic [31:0]        rng;

	zx_pager_top dut
	(
		.fclk(fclk), .rst(rst), .a(a), .d_in(d_in),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
		.d_out(d_out), .d_oe(d_oe), .mem_page(mem_page), .mem_rom(mem_rom),
		.border(border), .dos(dos)
	);

	bind zx_pager_top zx_pager_checker chk
	(
		.fclk(fclk), .rst(rst), .a(a), .d_in(d_in),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
		.d_out(d_out), .d_oe(d_oe), .mem_page(mem_page), .mem_rom(mem_rom),
		.border(border), .dos(dos)
	);

	initial
		fclk = 1'b0;
	always
		#(CLK_NS / 2) fclk = ~fclk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// strobes low for 6 cycles, then 3 idle cycles
	task automatic end_cycle();
		repeat (6) @(posedge fclk);
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		repeat (3) @(posedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a      <= addr;
		d_in   <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		end_cycle();
	endtask

	task automatic io_read(input logic [15:0] addr);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		end_cycle();
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		a      <= addr;
		mreq_n <= 1'b0;
		m1_n   <= 1'b0;
		rd_n   <= 1'b0;
		end_cycle();
	endtask

	// visit each 16k window with a random offset
	task automatic sweep_windows();
		for (int w = 0; w < `NUM_WIN; w++)
		begin
			rng = xorshift(rng);
			a <= {w[1:0], rng[13:0]};
			@(posedge fclk);
		end
	endtask

	always @(posedge fclk)
	begin
		if (dut.chk.err_count != 0)
		begin
			$display("[ERROR] %0t ns: checker assertion failed, see the message above", $time);
			$display("TB FAILED");
			$fatal(1, "stopped at first checker failure");
		end
	end

	initial
	begin
		#(TEST_CYCLES * 12 * CLK_NS);
		$display("watchdog expired before the test list finished");
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		rng    = 32'hcc49_1d47;
		rst    = 1'b1;
		a      = '0;
		d_in   = '0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		repeat (4) @(posedge fclk);
		rst <= 1'b0;
		@(posedge fclk);
		sweep_windows();

		// 128k mode, random banks and rom select
		io_write(`PORT_EFF7, 8'h04);
		for (int i = 0; i < 8; i++)
		begin
			rng = xorshift(rng);
			io_write(`PORT_7FFD, rng[7:0] & 8'hDF);
			sweep_windows();
		end

		// lock, then writes that must be ignored
		io_write(`PORT_7FFD, 8'h23);
		for (int i = 0; i < 2; i++)
		begin
			rng = xorshift(rng);
			io_write(`PORT_7FFD, rng[7:0]);
			sweep_windows();
		end

		// 1M mode frees the lock and extends window 3
		io_write(`PORT_EFF7, 8'h00);
		sweep_windows();
		for (int i = 0; i < 2; i++)
		begin
			rng = xorshift(rng);
			io_write(`PORT_7FFD, rng[7:0] | 8'hC0);
			sweep_windows();
		end

		// ram page 0 at 0000
		io_write(`PORT_EFF7, 8'h08);
		sweep_windows();
		io_write(`PORT_EFF7, 8'h00);

		// no dos entry while the 128k rom is selected
		io_write(`PORT_7FFD, 8'h00);
		m1_fetch(16'h3D2F);

		// dos entry and exit
		io_write(`PORT_7FFD, 8'h10);
		m1_fetch(16'h3D2F);
		sweep_windows();
		m1_fetch(16'h1234);
		m1_fetch(16'h8000);
		sweep_windows();

		// border, partial decode on the low byte
		for (int i = 0; i < 4; i++)
		begin
			rng = xorshift(rng);
			io_write({rng[15:8], `PORT_FE_LO}, rng[23:16]);
		end

		// readback of the window table
		for (int i = 0; i < 6; i++)
			io_read({i[7:0], `PORT_BE_LO});
		io_read({8'hFF, `PORT_BE_LO});
		io_read(16'h00FE);
		io_read(`PORT_7FFD);

		repeat (4) @(posedge fclk);
		if (dut.chk.err_count == 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("TB FAILED");
			$fatal(1, "checker reported failures");
		end
	end

endmodule

`default_nettype wire

// ==== zx_bus_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

module zx_bus_decode import zx_bus_pkg::*;
(
	input  logic               fclk,
	input  logic               rst,

	input  logic [`ADDR_W-1:0] a,
	input  logic [`DATA_W-1:0] d_in,
	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,

	port_cycle_if.source       cyc
);

	// sampled bus
	logic               iorq_s, mreq_s, rd_s, wr_s, m1_s;
	logic [`ADDR_W-1:0] a_s;
	logic [`DATA_W-1:0] d_s;

	cycle_kind_e kind_s;
	cycle_kind_e kind_p;
	logic        start;

	////////////////////////////////////////////////////////////////////////////
	// input sampling
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			iorq_s <= 1'b1;
			mreq_s <= 1'b1;
			rd_s   <= 1'b1;
			wr_s   <= 1'b1;
			m1_s   <= 1'b1;
		end
		else
		begin
			iorq_s <= iorq_n;
			mreq_s <= mreq_n;
			rd_s   <= rd_n;
			wr_s   <= wr_n;
			m1_s   <= m1_n;
		end
	end

	always_ff @(posedge fclk)
	begin
		a_s <= a;
		d_s <= d_in;
	end

	// classify the sampled cycle, port address is not looked at here
	always_comb
	begin
		kind_s = none;
		if (!iorq_s && m1_s && !wr_s)
			kind_s = port_write;
		else if (!iorq_s && m1_s && !rd_s)
			kind_s = port_read;
		else if (!mreq_s && !m1_s && !rd_s)
			kind_s = m1_fetch;
	end

	// first sample of a new cycle
	assign start = (kind_s != none) && (kind_s != kind_p);

	////////////////////////////////////////////////////////////////////////////
	// strobe generation
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			kind_p        <= none;
			cyc.stb       <= 1'b0;
			cyc.kind      <= none;
			cyc.rd_active <= 1'b0;
		end
		else
		begin
			kind_p        <= kind_s;
			cyc.stb       <= start;
			cyc.rd_active <= (kind_s == port_read);
			if (start)
				cyc.kind <= kind_s;
		end
	end

	// captured with the strobe
	always_ff @(posedge fclk)
	begin
		if (start)
		begin
			cyc.addr  <= a_s;
			cyc.wdata <= d_s;
		end
	end

endmodule

`default_nettype wire

// ==== zx_bus_pkg.sv ====
`default_nettype none

`include "zx_params.svh"

package zx_bus_pkg;

	// high byte selects readback item, low byte picks the port
	typedef struct packed
	{
		logic [`ADDR_W/2-1:0] hi;
		logic [`ADDR_W/2-1:0] lo;
	} port_bytes_t;

	// full word for 7ffd/eff7, split bytes for fe and xxbe
	typedef union packed
	{
		logic [`ADDR_W-1:0] word;
		port_bytes_t        bytes;
	} port_addr_u;

	// kind of z80 bus cycle seen by the decoder
	typedef enum logic [1:0]
	{
		none,
		port_write,
		port_read,
		m1_fetch
	} cycle_kind_e;

endpackage

`default_nettype wire

// ==== zx_map_pkg.sv ====
`default_nettype none

`include "zx_params.svh"

package zx_map_pkg;

	// physical page number, ram or rom
	typedef logic [`PAGE_W-1:0] page_t;

	// one of the four 16k cpu windows
	typedef logic [$clog2(`NUM_WIN)-1:0] win_idx_t;

	// what a window points at
	typedef struct packed
	{
		logic  rom;
		page_t page;
	} win_map_t;

endpackage

`default_nettype wire

// ==== zx_mem_pager.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

module zx_mem_pager import zx_map_pkg::*;
(
	input  logic [`ADDR_W-1:0] a,

	map_state_if.sink          st,

	output win_map_t           win [`NUM_WIN],
	output page_t              mem_page,
	output logic               mem_rom
);

	win_idx_t sel;
	logic     one_meg;

	// 1M mode while eff7 bit 2 is clear
	assign one_meg = !st.eff7[2];

	always_comb
	begin
		// window 0, rom unless ram0 mapped by eff7
		if (st.eff7[3])
		begin
			win[0].rom  = 1'b0;
			win[0].page = '0;
		end
		else
		begin
			win[0].rom  = 1'b1;
			win[0].page = {{(`PAGE_W-2){1'b0}}, ~st.dos, st.p7ffd[4]};
		end

		win[1].rom  = 1'b0;
		win[1].page = `RAM_PAGE_WIN1;

		win[2].rom  = 1'b0;
		win[2].page = `RAM_PAGE_WIN2;

		// window 3, banked ram
		win[3].rom  = 1'b0;
		win[3].page = {{(`PAGE_W-5){1'b0}},
		               one_meg ? st.p7ffd[7:6] : 2'b00,
		               st.p7ffd[2:0]};
	end

	// window of the current cpu address
	assign sel      = a[`ADDR_W-1 -: $bits(win_idx_t)];
	assign mem_page = win[sel].page;
	assign mem_rom  = win[sel].rom;

endmodule

`default_nettype wire

// ==== zx_pager_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

module zx_pager_checker import zx_bus_pkg::*, zx_map_pkg::*;
(
	input logic               fclk,
	input logic               rst,
	input logic [`ADDR_W-1:0] a,
	input logic [`DATA_W-1:0] d_in,
	input logic               iorq_n,
	input logic               mreq_n,
	input logic               rd_n,
	input logic               wr_n,
	input logic               m1_n,
	input logic [`DATA_W-1:0] d_out,
	input logic               d_oe,
	input logic [`PAGE_W-1:0] mem_page,
	input logic               mem_rom,
	input logic [2:0]         border,
	input logic               dos
);

	int err_count = 0;

	logic [4:0]         bus_q;
	logic [`ADDR_W-1:0] a_q, pend_addr;
	logic [`DATA_W-1:0] d_q, pend_data;
	cycle_kind_e        kind_q, prev_kind, pend_kind;
	logic               pend, rd_act;

	// model of the paging state
	logic [`DATA_W-1:0] m_p7ffd, m_eff7, m_dout;
	logic [2:0]         m_border;
	logic               m_dos, m_oe, m_lock;
	win_map_t           exp_map;

	// window entry as the memory map rules give it
	function automatic win_map_t exp_win(input logic [1:0] w, input logic [7:0] p,
	                                     input logic [7:0] e, input logic d);
		win_map_t r;
		r.rom  = 1'b0;
		r.page = (w == 2'd1) ? `RAM_PAGE_WIN1 : `RAM_PAGE_WIN2;
		if (w == 2'd0)
		begin
			r.rom  = !e[3];
			r.page = e[3] ? 8'd0 : {6'd0, !d, p[4]};
		end
		else if (w == 2'd3)
			r.page = {3'd0, e[2] ? 2'b00 : p[7:6], p[2:0]};
		return r;
	endfunction

	function automatic logic [7:0] rb_value(input logic [7:0] hi, input logic [7:0] p,
	                                        input logic [7:0] e, input logic d);
		win_map_t   w0;
		win_map_t   w1;
		win_map_t   w2;
		win_map_t   w3;
		win_map_t   item;
		logic [3:0] roms;
		w0   = exp_win(2'd0, p, e, d);
		w1   = exp_win(2'd1, p, e, d);
		w2   = exp_win(2'd2, p, e, d);
		w3   = exp_win(2'd3, p, e, d);
		item = exp_win(hi[1:0], p, e, d);
		roms = {w3.rom, w2.rom, w1.rom, w0.rom};
		if (hi < 8'd4)
			return item.page;
		else if (hi == 8'd4)
			return {4'h0, roms};
		return 8'hFF;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus cycle tracking, one sample stage and one strobe stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		bus_q <= rst ? 5'h1F : {iorq_n, mreq_n, rd_n, wr_n, m1_n};
		a_q   <= a;
		d_q   <= d_in;
	end

	always_comb
	begin
		kind_q = none;
		if (!bus_q[4] && bus_q[0] && !bus_q[1])
			kind_q = port_write;
		else if (!bus_q[4] && bus_q[0] && !bus_q[2])
			kind_q = port_read;
		else if (!bus_q[3] && !bus_q[0] && !bus_q[2])
			kind_q = m1_fetch;
	end

	always_ff @(posedge fclk)
	begin
		prev_kind <= rst ? none : kind_q;
		pend      <= !rst && (kind_q != none) && (kind_q != prev_kind);
		rd_act    <= !rst && (kind_q == port_read);
		pend_kind <= kind_q;
		pend_addr <= a_q;
		pend_data <= d_q;
	end

	assign m_lock = m_p7ffd[5] && m_eff7[2];

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			m_p7ffd  <= '0;
			m_eff7   <= '0;
			m_border <= 3'd0;
			m_dos    <= 1'b0;
			m_oe     <= 1'b0;
			m_dout   <= '0;
		end
		else
		begin
			if (pend && pend_kind == port_write)
			begin
				if (pend_addr == `PORT_7FFD && !m_lock)
					m_p7ffd <= pend_data;
				if (pend_addr == `PORT_EFF7)
					m_eff7 <= pend_data;
				if (pend_addr[7:0] == `PORT_FE_LO)
					m_border <= pend_data[2:0];
			end
			if (pend && pend_kind == m1_fetch)
			begin
				if (pend_addr[15:8] == `DOS_ENTRY_HI && m_p7ffd[4])
					m_dos <= 1'b1;
				else if (pend_addr >= 16'h4000)
					m_dos <= 1'b0;
			end
			if (pend && pend_kind == port_read && pend_addr[7:0] == `PORT_BE_LO)
			begin
				m_oe   <= 1'b1;
				m_dout <= rb_value(pend_addr[15:8], m_p7ffd, m_eff7, m_dos);
			end
			else if (!rd_act)
				m_oe <= 1'b0;
		end
	end

	always_comb
		exp_map = exp_win(a[15:14], m_p7ffd, m_eff7, m_dos);

	////////////////////////////////////////////////////////////////////////////
	// output checks
	////////////////////////////////////////////////////////////////////////////

	a_border: assert property (@(posedge fclk) disable iff (rst) border == m_border)
		else
		begin
			$error("border is %0d, model has %0d", border, m_border);
			err_count++;
		end

	a_dos: assert property (@(posedge fclk) disable iff (rst) dos == m_dos)
		else
		begin
			$error("dos is %0b, model has %0b", dos, m_dos);
			err_count++;
		end

	a_map: assert property (@(posedge fclk) disable iff (rst)
		mem_rom == exp_map.rom && mem_page == exp_map.page)
		else
		begin
			$error("a=%h gives rom=%0b page=%h, model has rom=%0b page=%h",
			       a, mem_rom, mem_page, exp_map.rom, exp_map.page);
			err_count++;
		end

	a_oe: assert property (@(posedge fclk) disable iff (rst) d_oe == m_oe)
		else
		begin
			$error("d_oe is %0b, model has %0b", d_oe, m_oe);
			err_count++;
		end

	a_dout: assert property (@(posedge fclk) disable iff (rst) d_oe |-> d_out == m_dout)
		else
		begin
			$error("d_out is %h, model has %h", d_out, m_dout);
			err_count++;
		end

endmodule

`default_nettype wire

// ==== zx_pager_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

module zx_pager_top import zx_map_pkg::*;
(
	input  logic               fclk,
	input  logic               rst,

	// z80
	input  logic [`ADDR_W-1:0] a,
	input  logic [`DATA_W-1:0] d_in,
	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,

	output logic [`DATA_W-1:0] d_out,
	output logic               d_oe,

	// memory side
	output logic [`PAGE_W-1:0] mem_page,
	output logic               mem_rom,

	output logic [2:0]         border,
	output logic               dos
);

	port_cycle_if cyc ();
	map_state_if  st ();

	win_map_t win [`NUM_WIN];

	zx_bus_decode bus_decode
	(
		.fclk  (fclk  ),
		.rst   (rst   ),
		.a     (a     ),
		.d_in  (d_in  ),
		.iorq_n(iorq_n),
		.mreq_n(mreq_n),
		.rd_n  (rd_n  ),
		.wr_n  (wr_n  ),
		.m1_n  (m1_n  ),
		.cyc   (cyc   )
	);

	zx_port_regs port_regs
	(
		.fclk  (fclk  ),
		.rst   (rst   ),
		.cyc   (cyc   ),
		.st    (st    ),
		.border(border)
	);

	zx_mem_pager mem_pager
	(
		.a       (a       ),
		.st      (st      ),
		.win     (win     ),
		.mem_page(mem_page),
		.mem_rom (mem_rom )
	);

	zx_port_readback port_readback
	(
		.fclk (fclk ),
		.rst  (rst  ),
		.cyc  (cyc  ),
		.win  (win  ),
		.d_out(d_out),
		.d_oe (d_oe )
	);

	assign dos = st.dos;

endmodule

`default_nettype wire

// ==== zx_params.svh ====
`ifndef ZX_PARAMS_SVH
`define ZX_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// bus and memory geometry
////////////////////////////////////////////////////////////////////////////

`define ADDR_W 16
`define DATA_W 8
`define PAGE_W 8
`define NUM_WIN 4

// fully decoded ports
`define PORT_7FFD 16'h7FFD
`define PORT_EFF7 16'hEFF7

// partially decoded ports, low byte only
`define PORT_FE_LO 8'hFE
`define PORT_BE_LO 8'hBE

// fixed ram pages of the middle windows
`define RAM_PAGE_WIN1 8'd5
`define RAM_PAGE_WIN2 8'd2

// fetches from this high byte may switch dos rom in
`define DOS_ENTRY_HI 8'h3D

`endif

// ==== zx_port_readback.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

module zx_port_readback import zx_bus_pkg::*, zx_map_pkg::*;
(
	input  logic               fclk,
	input  logic               rst,

	port_cycle_if.sink         cyc,
	input  win_map_t           win [`NUM_WIN],

	output logic [`DATA_W-1:0] d_out,
	output logic               d_oe
);

	logic                 be_read;
	logic [`NUM_WIN-1:0]  rom_bits;
	logic [`DATA_W-1:0]   rb_data;
	win_idx_t             rb_win;

	assign be_read = cyc.stb && (cyc.kind == port_read) &&
	                 (cyc.addr.bytes.lo == `PORT_BE_LO);

	assign rom_bits = {win[3].rom, win[2].rom, win[1].rom, win[0].rom};
	assign rb_win   = cyc.addr.bytes.hi[$bits(win_idx_t)-1:0];

	// item chosen by the high address byte
	always_comb
	begin
		if (cyc.addr.bytes.hi < `NUM_WIN)
			rb_data = win[rb_win].page;
		else if (cyc.addr.bytes.hi == `NUM_WIN)
			rb_data = {{(`DATA_W-`NUM_WIN){1'b0}}, rom_bits};
		else
			rb_data = 8'hFF;
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			d_oe <= 1'b0;
		else if (be_read)
			d_oe <= 1'b1;
		else if (!cyc.rd_active)
			d_oe <= 1'b0;
	end

	// held for the rest of the read cycle
	always_ff @(posedge fclk)
	begin
		if (be_read)
			d_out <= rb_data;
	end

endmodule

`default_nettype wire

// ==== zx_port_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_params.svh"

module zx_port_regs import zx_bus_pkg::*, zx_map_pkg::*;
(
	input  logic         fclk,
	input  logic         rst,

	port_cycle_if.sink   cyc,
	map_state_if.source  st,

	output logic [2:0]   border
);

	logic     lock;
	logic     wr_stb;
	logic     m1_stb;
	win_idx_t fetch_win;

	// 128k lock only holds with 1M mode off
	assign lock = st.p7ffd[5] && st.eff7[2];

	assign wr_stb = cyc.stb && (cyc.kind == port_write);
	assign m1_stb = cyc.stb && (cyc.kind == m1_fetch);

	// window of the opcode fetch
	assign fetch_win = cyc.addr.word[`ADDR_W-1 -: $bits(win_idx_t)];

	////////////////////////////////////////////////////////////////////////////
	// port writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			st.p7ffd <= '0;
			st.eff7  <= '0;
			border   <= 3'd0;
		end
		else if (wr_stb)
		begin
			if ((cyc.addr.word == `PORT_7FFD) && !lock)
				st.p7ffd <= cyc.wdata;

			if (cyc.addr.word == `PORT_EFF7)
				st.eff7 <= cyc.wdata;

			// border decoded on the low byte only
			if (cyc.addr.bytes.lo == `PORT_FE_LO)
				border <= cyc.wdata[2:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// dos flag from m1 fetches
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
			st.dos <= 1'b0;
		else if (m1_stb)
		begin
			// entry into 3Dxx while basic48 rom is on
			if ((cyc.addr.bytes.hi == `DOS_ENTRY_HI) && st.p7ffd[4])
				st.dos <= 1'b1;
			// any fetch outside the rom window leaves dos
			else if (fetch_win != '0)
				st.dos <= 1'b0;
		end
	end

endmodule

`default_nettype wire
